// File: verilog/decompose_consts.svh
`ifndef DECOMPOSE_CONSTS_SVH
`define DECOMPOSE_CONSTS_SVH

// ========================================
// Dilithium field and decompose constants
// ========================================

// Prime modulus q of the Dilithium ring
`define DILITHIUM_Q 23'd8380417

// GAMMA2 = (q-1)/32, the set used by ML-DSA-65 and ML-DSA-87
// With this choice r1 takes 16 values and fits in 4 bits
`define DILITHIUM_GAMMA2 23'd261888

// Width of one coefficient in [0, q-1]
`define COEFF_WIDTH 23

// Width of the high bits r1
`define R1_WIDTH 4

// Width of the centered low bits r0, two's complement
// GAMMA2 is below 2^19, so 20 bits hold the full signed range
`define R0_WIDTH 20

`endif

// File: verilog/dilithium_coeff_pkg.sv
`default_nettype none

`include "decompose_consts.svh"

// Value types for coefficients and their decomposition
package dilithium_coeff_pkg;

    // ========================================
    // Scalar types
    // ========================================

    // Unsigned coefficient in [0, q-1]
    typedef logic [`COEFF_WIDTH-1:0] coeff_t;

    // High bits of a coefficient, 0 to 15
    typedef logic [`R1_WIDTH-1:0] r1_t;

    // Centered low bits, signed
    typedef logic signed [`R0_WIDTH-1:0] r0_t;

    // ========================================
    // Decomposition result
    // ========================================

    // One decomposed coefficient, r = r1*2*GAMMA2 + r0 (mod q)
    // z_nez is kept with the pair so the signature check needs no extra compare
    typedef struct packed {
        r1_t  r1;
        r0_t  r0;
        logic z_nez;
    } decomp_t;

endpackage

`default_nettype wire

// File: verilog/decompose_stream_pkg.sv
`default_nettype none

// Items that move down the decompose pipeline
// Each item carries its own valid so a new coefficient can enter every cycle
package decompose_stream_pkg;

    import dilithium_coeff_pkg::*;

    // Input item, one coefficient and its hint bit
    typedef struct packed {
        logic   valid;
        logic   hint;
        coeff_t r;
    } coeff_in_t;

    // Between the two stages
    // The hint rides along untouched until UseHint is applied
    typedef struct packed {
        logic    valid;
        logic    hint;
        decomp_t decomp;
    } decomp_item_t;

    // Output item, the decomposition plus the hint-corrected high bits
    typedef struct packed {
        logic    valid;
        r1_t     r1_used;
        decomp_t decomp;
    } result_t;

endpackage

`default_nettype wire

// File: verilog/decompose_r1_lut.sv
`default_nettype none

`include "decompose_consts.svh"

// Range lookup for the high bits of a coefficient
// r1 = k when (2k-1)*GAMMA2 < r <= (2k+1)*GAMMA2, and 0 for r <= GAMMA2
// Above 31*GAMMA2 the value wraps around q, so r1 is forced back to 0
module decompose_r1_lut
    import dilithium_coeff_pkg::*;
(
    input  wire coeff_t r,
    output r1_t         r1,
    output logic        r_corner,
    output logic        z_nez
);

    // Number of distinct r1 values
    localparam int unsigned NUM_R1 = 1 << `R1_WIDTH;

    localparam int unsigned GAMMA2 = `DILITHIUM_GAMMA2;

    // Upper end of the regular range, 31*GAMMA2
    localparam int unsigned TOP_BOUND = (2 * NUM_R1 - 1) * GAMMA2;

    // ========================================
    // High bits selection
    // ========================================

    // Each window is 2*GAMMA2 wide and centered on k*2*GAMMA2
    // At most one window matches, everything outside them stays at 0
    always_comb begin
        r1 = '0;
        for (int unsigned k = 1; k < NUM_R1; k++) begin
            if ((r > (2 * k - 1) * GAMMA2) && (r <= (2 * k + 1) * GAMMA2)) begin
                r1 = r1_t'(k);
            end
        end
    end

    // Corner flag covers 31*GAMMA2 and up
    // At exactly 31*GAMMA2 r1 is still 15, so the r0 datapath also checks r1
    always_comb begin
        r_corner = (r >= TOP_BOUND);
    end

    // Nonzero flag of the high bits
    always_comb begin
        z_nez = (r1 != '0);
    end

endmodule

`default_nettype wire

// File: verilog/decompose_r0_calc.sv
`default_nettype none

`include "decompose_consts.svh"

// Centered low bits of a coefficient
// r0 = r - 2*GAMMA2*r1 in the regular range and r0 = r - q in the corner range
module decompose_r0_calc
    import dilithium_coeff_pkg::*;
(
    input  wire coeff_t r,
    input  wire r1_t    r1,
    input  wire         r_corner,
    output r0_t         r0
);

    // Step between two neighbouring r1 values
    localparam coeff_t TWO_GAMMA2 = `COEFF_WIDTH'(2 * `DILITHIUM_GAMMA2);

    // r1 * 2*GAMMA2, at most 15*2*GAMMA2 which still fits in a coefficient
    coeff_t prod;

    // Value removed from r
    coeff_t subtrahend;

    // One extra bit so the corner difference keeps its sign
    logic signed [`COEFF_WIDTH:0] diff;

    // ========================================
    // Multiple of 2*GAMMA2
    // ========================================

    // Shift and add over the four bits of r1, no multiplier needed
    always_comb begin
        prod = '0;
        for (int i = 0; i < `R1_WIDTH; i++) begin
            if (r1[i]) begin
                prod = prod + (TWO_GAMMA2 << i);
            end
        end
    end

    // In the corner range r1 was forced to 0 and r sits just below q
    // so subtracting q gives the small negative r0
    always_comb begin
        subtrahend = (r_corner && (r1 == '0)) ? `DILITHIUM_Q : prod;
    end

    always_comb begin
        diff = $signed({1'b0, r}) - $signed({1'b0, subtrahend});
    end

    // Result lies in [-GAMMA2, GAMMA2], the low 20 bits carry it exactly
    always_comb begin
        r0 = diff[`R0_WIDTH-1:0];
    end

endmodule

`default_nettype wire

// File: verilog/decompose_stage.sv
`default_nettype none

// First pipeline stage
// Decomposes the incoming coefficient and registers it with its hint and valid
module decompose_stage
    import dilithium_coeff_pkg::*;
    import decompose_stream_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire coeff_in_t    in,
    output decomp_item_t      out
);

    // Lookup results
    r1_t  lut_r1;
    logic lut_corner;
    logic lut_z_nez;

    // Low bits from the subtract path
    r0_t calc_r0;

    // Decomposition ahead of the register
    decomp_t decomp_d;

    // ========================================
    // Combinational decompose
    // ========================================

    decompose_r1_lut r1_lut_i (
        .r        (in.r),
        .r1       (lut_r1),
        .r_corner (lut_corner),
        .z_nez    (lut_z_nez)
    );

    // r0 depends on r1 from the lookup, so this path is the longest of the stage
    decompose_r0_calc r0_calc_i (
        .r        (in.r),
        .r1       (lut_r1),
        .r_corner (lut_corner),
        .r0       (calc_r0)
    );

    always_comb begin
        decomp_d.r1    = lut_r1;
        decomp_d.r0    = calc_r0;
        decomp_d.z_nez = lut_z_nez;
    end

    // ========================================
    // Stage register
    // ========================================

    // Only the valid bit is cleared, the payload just loads on a strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
        if (in.valid) begin
            out.hint   <= in.hint;
            out.decomp <= decomp_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hint_apply.sv
`default_nettype none

// Second pipeline stage
// Applies UseHint to the high bits and registers the final result
module hint_apply
    import dilithium_coeff_pkg::*;
    import decompose_stream_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire decomp_item_t in,
    output result_t           out
);

    // Local copy of r0 so the compare below stays signed
    r0_t r0_val;

    // High when r0 is strictly positive
    logic r0_pos;

    // Both neighbours of r1, wrapping modulo 16 through the 4-bit width
    r1_t r1_inc;
    r1_t r1_dec;

    // Corrected high bits ahead of the register
    r1_t r1_used_d;

    // ========================================
    // UseHint
    // ========================================

    always_comb begin
        r0_val = in.decomp.r0;
        r0_pos = (r0_val > r0_t'(0));
    end

    // 15 + 1 gives 0 and 0 - 1 gives 15
    always_comb begin
        r1_inc = in.decomp.r1 + r1_t'(1);
        r1_dec = in.decomp.r1 - r1_t'(1);
    end

    // r0 of zero counts as not positive and takes the decrement
    always_comb begin
        if (!in.hint) begin
            r1_used_d = in.decomp.r1;
        end else if (r0_pos) begin
            r1_used_d = r1_inc;
        end else begin
            r1_used_d = r1_dec;
        end
    end

    // ========================================
    // Output register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
        if (in.valid) begin
            out.r1_used <= r1_used_d;
            out.decomp  <= in.decomp;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decompose_top.sv
`default_nettype none

// Coefficient decompose unit
// Two register stages, so results appear 2 cycles after each in_valid strobe
module decompose_top
    import dilithium_coeff_pkg::*;
    import decompose_stream_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         in_valid,
    input  wire         in_hint,
    input  wire coeff_t in_r,
    output logic        out_valid,
    output r1_t         out_r1,
    output r0_t         out_r0,
    output logic        out_z_nez,
    output r1_t         out_r1_used
);

    // Items along the pipeline
    coeff_in_t    stage_in;
    decomp_item_t stage_out;
    result_t      result;

    // Pack the loose input pins into one item
    assign stage_in = '{valid: in_valid, hint: in_hint, r: in_r};

    decompose_stage decompose_stage_i (
        .clk   (clk),
        .reset (reset),
        .in    (stage_in),
        .out   (stage_out)
    );

    hint_apply hint_apply_i (
        .clk   (clk),
        .reset (reset),
        .in    (stage_out),
        .out   (result)
    );

    // Unpack the result item onto the output ports
    assign out_valid   = result.valid;
    assign out_r1      = result.decomp.r1;
    assign out_r0      = result.decomp.r0;
    assign out_z_nez   = result.decomp.z_nez;
    assign out_r1_used = result.r1_used;

endmodule

`default_nettype wire

// File: sim/decompose_chk.sv
`default_nettype none

`include "decompose_consts.svh"

// Protocol and range checks on the output register of hint_apply
module decompose_chk
    import dilithium_coeff_pkg::*;
(
    input wire       clk,
    input wire       reset,
    input wire       in_valid,
    input wire       out_valid,
    input wire r1_t  r1,
    input wire r0_t  r0,
    input wire       z_nez
);

    localparam int GAMMA2 = `DILITHIUM_GAMMA2;

    // Number of assertion failures so far
    int fail_count = 0;

    // ========================================
    // Valid timing
    // ========================================

    // One register between in and out, so out valid is in valid delayed by one edge
    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (out_valid == $past(in_valid)))
        else begin
            fail_count++;
            $error("out valid does not follow in valid by one cycle");
        end

    // A reset edge always clears the output valid
    assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out valid high after a reset edge");
        end

    // ========================================
    // Result ranges
    // ========================================

    // The corner value 31*GAMMA2+1 lands exactly on -GAMMA2, so the lower end is closed
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> ((r0 >= -GAMMA2) && (r0 <= GAMMA2)))
        else begin
            fail_count++;
            $error("r0 outside the centered range");
        end

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (z_nez == (r1 != '0)))
        else begin
            fail_count++;
            $error("z_nez does not match r1");
        end

endmodule

bind hint_apply decompose_chk decompose_chk_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in.valid),
    .out_valid (out.valid),
    .r1        (out.decomp.r1),
    .r0        (out.decomp.r0),
    .z_nez     (out.decomp.z_nez)
);

`default_nettype wire

// File: sim/tb_decompose_top.sv
`default_nettype none

module tb_decompose_top
    import dilithium_coeff_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam string GOLDEN_FILE = "sim/decompose_golden.txt";

    // One golden vector, stimulus and expected result together
    typedef struct packed {
        coeff_t r;
        logic   hint;
        r1_t    r1;
        r0_t    r0;
        logic   z_nez;
        r1_t    r1_used;
    } golden_vec_t;

    logic   clk;
    logic   reset;
    logic   in_valid;
    logic   in_hint;
    coeff_t in_r;
    logic   out_valid;
    r1_t    out_r1;
    r0_t    out_r0;
    logic   out_z_nez;
    r1_t    out_r1_used;

    golden_vec_t vecs[$];
    // Vector index per driven cycle, -1 marks an idle cycle
    int          exp_q[$];
    logic        load_done;

    decompose_top decompose_top_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_hint     (in_hint),
        .in_r        (in_r),
        .out_valid   (out_valid),
        .out_r1      (out_r1),
        .out_r0      (out_r0),
        .out_z_nez   (out_z_nez),
        .out_r1_used (out_r1_used)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    task automatic compare_value(input string what, input integer got, input integer expected);
        if (got !== expected) begin
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        integer      f_r, f_hint, f_r1, f_r0, f_z, f_used;
        golden_vec_t v;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file %s", GOLDEN_FILE);
            $display("Simulation failed");
            $fatal(1, "Missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Header lines start with a hash and blank lines carry nothing
            if ((line.len() > 0) && (line[0] != "#")) begin
                n = $sscanf(line, "%d %d %d %d %d %d", f_r, f_hint, f_r1, f_r0, f_z, f_used);
                if (n == 6) begin
                    v.r       = coeff_t'(f_r);
                    v.hint    = f_hint[0];
                    v.r1      = r1_t'(f_r1);
                    v.r0      = r0_t'(f_r0);
                    v.z_nez   = f_z[0];
                    v.r1_used = r1_t'(f_used);
                    vecs.push_back(v);
                end
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("The golden vector file holds no vectors");
            $display("Simulation failed");
            $fatal(1, "Empty stimulus file");
        end
        load_done = 1'b1;
    endtask

    // Outputs are sampled on the falling edge, halfway between two register updates
    task automatic check_result(input int idx);
        if (idx < 0) begin
            compare_value("out_valid", out_valid, 0);
        end else begin
            compare_value("out_valid", out_valid, 1);
            compare_value("out_r1", out_r1, vecs[idx].r1);
            compare_value("out_r0", $signed(out_r0), $signed(vecs[idx].r0));
            compare_value("out_z_nez", out_z_nez, vecs[idx].z_nez);
            compare_value("out_r1_used", out_r1_used, vecs[idx].r1_used);
        end
    endtask

    // The result of a strobe shows up two falling edges after it was driven
    task automatic advance_cycle(input int idx);
        int front;
        @(negedge clk);
        if (exp_q.size() == 2) begin
            front = exp_q.pop_front();
            check_result(front);
        end
        if (idx < 0) begin
            in_valid = 1'b0;
            in_hint  = 1'b0;
            in_r     = '0;
        end else begin
            in_valid = 1'b1;
            in_hint  = vecs[idx].hint;
            in_r     = vecs[idx].r;
        end
        exp_q.push_back(idx);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_hint     = 1'b0;
        in_r        = '0;
        load_done   = 1'b0;
        load_vectors();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_value("out_valid during reset", out_valid, 0);
        end
        reset = 1'b0;

        // Two idle slots so out_valid is checked low right after reset
        exp_q.push_back(-1);
        exp_q.push_back(-1);

        // All vectors back to back, one strobe per cycle
        for (int i = 0; i < vecs.size(); i++) begin
            advance_cycle(i);
        end

        // Drain and confirm each pulse lasts a single cycle
        repeat (4) begin
            advance_cycle(-1);
        end

        $display("Simulation completed successfully");
        $finish;
    end

    // Any failed assertion on the hint stage ends the run
    initial begin
        wait (decompose_top_i.hint_apply_i.decompose_chk_i.fail_count != 0);
        $display("ERROR at time %0t: an assertion on the hint stage failed", $time);
        $display("Simulation failed");
        $fatal(1, "Assertion failure");
    end

    // Watchdog sized from the vector count, the reset and some slack
    initial begin
        wait (load_done === 1'b1);
        #((vecs.size() + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("Timeout, the run did not finish in the expected time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/dilithium_coeff_pkg.sv
verilog/decompose_stream_pkg.sv
verilog/decompose_r1_lut.sv
verilog/decompose_r0_calc.sv
verilog/decompose_stage.sv
verilog/hint_apply.sv
verilog/decompose_top.sv
sim/decompose_chk.sv
sim/tb_decompose_top.sv

// File: sim/decompose_golden.txt
# Columns: r hint r1 r0 z_nez r1_used, all decimal, r0 signed
# Odd multiples of GAMMA2 and one above, plus corner range and hint wraparounds
0 1 0 0 0 15
261888 0 0 261888 0 0
261889 1 1 -261887 1 0
785664 1 1 261888 1 2
785665 0 2 -261887 1 2
1309440 0 2 261888 1 2
1309441 1 3 -261887 1 2
1833216 0 3 261888 1 3
1833217 0 4 -261887 1 4
2356992 1 4 261888 1 5
2356993 0 5 -261887 1 5
2618880 1 5 0 1 4
2880768 0 5 261888 1 5
2880769 0 6 -261887 1 6
3404544 0 6 261888 1 6
3404545 1 7 -261887 1 6
3928320 0 7 261888 1 7
3928321 0 8 -261887 1 8
4452096 1 8 261888 1 9
4452097 0 9 -261887 1 9
4975872 0 9 261888 1 9
4975873 0 10 -261887 1 10
5499648 0 10 261888 1 10
5499649 1 11 -261887 1 10
6023424 0 11 261888 1 11
6023425 0 12 -261887 1 12
6547200 0 12 261888 1 12
6547201 0 13 -261887 1 13
7070976 1 13 261888 1 14
7070977 0 14 -261887 1 14
7594752 0 14 261888 1 14
7594753 1 15 -261887 1 14
8118528 1 15 261888 1 0
8118529 1 0 -261888 0 15
8250000 0 0 -130417 0 0
8380416 1 0 -1 0 15
